// File: include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data word width
`define CPU_XLEN 32

// byte address on the shared APB bus
`define CPU_ADDR_W 16

// first fetch address after reset
`define CPU_RESET_PC 16'h0000

// register index width, 32 registers
`define CPU_REG_ADDR_W 5

// ecall, used as the halt instruction
`define CPU_HALT_INST 32'h0000_0073

`endif

// File: src/isa_pkg.sv
`include "cpu_params.svh"

package isa_pkg;

    // major opcodes of the supported subset
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_system = 7'b1110011;

    // nine classes need a fourth bit
    typedef enum logic [3:0] {
        cls_alu_reg,
        cls_alu_imm,
        cls_lui,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_halt,
        cls_illegal
    } inst_class_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_t;

    typedef struct packed {
        inst_class_t                cls;
        alu_op_t                    op;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [`CPU_XLEN-1:0]       rs1;
        logic [`CPU_XLEN-1:0]       rs2;
        logic [`CPU_XLEN-1:0]       imm;
        logic                       bne;
    } decoded_t;

endpackage

// File: src/bus_pkg.sv
`include "cpu_params.svh"

package bus_pkg;

    // master to slave side of an APB transfer
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`CPU_ADDR_W-1:0] paddr;
        logic [`CPU_XLEN-1:0]   pwdata;
    } apb_req_t;

    // slave to master side
    typedef struct packed {
        logic [`CPU_XLEN-1:0] prdata;
        logic                 pready;
    } apb_rsp_t;

endpackage

// File: src/regs.sv
`include "cpu_params.svh"

module regs (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       we,
    input  logic [`CPU_REG_ADDR_W-1:0] waddr,
    input  logic [`CPU_XLEN-1:0]       wdata,
    input  logic [`CPU_REG_ADDR_W-1:0] raddr1,
    input  logic [`CPU_REG_ADDR_W-1:0] raddr2,
    output logic [`CPU_XLEN-1:0]       rdata1,
    output logic [`CPU_XLEN-1:0]       rdata2
);

    logic [`CPU_XLEN-1:0] mem [0:(1 << `CPU_REG_ADDR_W)-1];

    // x0 is cleared here and never written, so it reads zero
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < (1 << `CPU_REG_ADDR_W); i++) begin
                mem[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata1 = mem[raddr1];
    assign rdata2 = mem[raddr2];

endmodule

// File: src/decode.sv
`include "cpu_params.svh"

module decode import isa_pkg::*; (
    input  logic [`CPU_XLEN-1:0]       inst,
    output logic [`CPU_REG_ADDR_W-1:0] rs1_addr,
    output logic [`CPU_REG_ADDR_W-1:0] rs2_addr,
    input  logic [`CPU_XLEN-1:0]       rs1_data,
    input  logic [`CPU_XLEN-1:0]       rs2_data,
    output decoded_t                   dec
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`CPU_XLEN-1:0] imm_i;
    logic [`CPU_XLEN-1:0] imm_s;
    logic [`CPU_XLEN-1:0] imm_b;
    logic [`CPU_XLEN-1:0] imm_u;
    logic [`CPU_XLEN-1:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // immediates per format, all sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec.cls = cls_illegal;
        dec.op  = alu_add;
        dec.rd  = inst[11:7];
        dec.rs1 = rs1_data;
        dec.rs2 = rs2_data;
        dec.imm = '0;
        dec.bne = funct3[0];

        case (opcode)
            opc_op: begin
                dec.cls = cls_alu_reg;
                case ({funct7, funct3})
                    10'b0000000_000: dec.op = alu_add;
                    10'b0100000_000: dec.op = alu_sub;
                    10'b0000000_111: dec.op = alu_and;
                    10'b0000000_110: dec.op = alu_or;
                    10'b0000000_100: dec.op = alu_xor;
                    10'b0000000_010: dec.op = alu_slt;
                    10'b0000000_001: dec.op = alu_sll;
                    10'b0000000_101: dec.op = alu_srl;
                    default:         dec.cls = cls_illegal;
                endcase
            end
            opc_imm: begin
                dec.imm = imm_i;
                // only addi
                if (funct3 == 3'b000) dec.cls = cls_alu_imm;
            end
            opc_lui: begin
                dec.cls = cls_lui;
                dec.imm = imm_u;
            end
            opc_load: begin
                dec.imm = imm_i;
                if (funct3 == 3'b010) dec.cls = cls_load;
            end
            opc_store: begin
                dec.imm = imm_s;
                if (funct3 == 3'b010) dec.cls = cls_store;
            end
            opc_branch: begin
                dec.imm = imm_b;
                // beq or bne
                if (funct3[2:1] == 2'b00) dec.cls = cls_branch;
            end
            opc_jal: begin
                dec.cls = cls_jal;
                dec.imm = imm_j;
            end
            opc_system: begin
                if (inst == `CPU_HALT_INST) dec.cls = cls_halt;
            end
            default: dec.cls = cls_illegal;
        endcase
    end

endmodule

// File: src/alu.sv
`include "cpu_params.svh"

module alu import isa_pkg::*; (
    input  alu_op_t              op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 equal
);

    logic [4:0] shamt;
    logic       less;

    assign shamt = b[4:0];

    // signed compare for slt
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {{(`CPU_XLEN-1){1'b0}}, less};
            alu_sll: result = a << shamt;
            alu_srl: result = a >> shamt;
            default: result = a + b;
        endcase
    end

    // beq and bne both look at this
    assign equal = (a == b);

endmodule

// File: src/bus_master.sv
`include "cpu_params.svh"

module bus_master import bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    input  logic                   write,
    input  logic [`CPU_ADDR_W-1:0] addr,
    input  logic [`CPU_XLEN-1:0]   wdata,
    output logic                   done,
    output logic [`CPU_XLEN-1:0]   rdata,
    output apb_req_t               req,
    input  apb_rsp_t               rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t state;
    logic   xfer_end;

    // last access cycle of the transfer
    assign xfer_end = (state == st_access) && rsp.pready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            done <= xfer_end;
            case (state)
                st_idle:   if (start) state <= st_setup;
                st_setup:  state <= st_access;
                st_access: if (rsp.pready) state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_end) rdata <= rsp.prdata;
    end

    // address and data are held by the core for the whole transfer
    assign req.psel    = (state != st_idle);
    assign req.penable = (state == st_access);
    assign req.pwrite  = write && (state != st_idle);
    assign req.paddr   = addr;
    assign req.pwdata  = wdata;

endmodule

// File: src/bus_arbiter.sv
module bus_arbiter import bus_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  apb_req_t fetch_req,
    input  apb_req_t data_req,
    output apb_rsp_t fetch_rsp,
    output apb_rsp_t data_rsp,
    output apb_req_t bus_req,
    input  apb_rsp_t bus_rsp
);

    logic busy;
    logic owner_data;
    logic grant_data;
    logic grant_fetch;

    // while idle the data port wins a tie
    assign grant_data  = busy ? owner_data : data_req.psel;
    assign grant_fetch = busy ? !owner_data : (!data_req.psel && fetch_req.psel);

    // owner taken at the setup cycle, released after the ending cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy       <= 1'b0;
            owner_data <= 1'b0;
        end else if (!busy) begin
            if (bus_req.psel) begin
                busy       <= 1'b1;
                owner_data <= data_req.psel;
            end
        end else if (bus_req.penable && bus_rsp.pready) begin
            busy <= 1'b0;
        end
    end

    assign bus_req = grant_data ? data_req : fetch_req;

    // prdata may go to both, only the owner sees pready
    assign fetch_rsp.prdata = bus_rsp.prdata;
    assign fetch_rsp.pready = bus_rsp.pready && grant_fetch;
    assign data_rsp.prdata  = bus_rsp.prdata;
    assign data_rsp.pready  = bus_rsp.pready && grant_data;

endmodule

// File: src/cpu.sv
`include "cpu_params.svh"

module cpu import isa_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    output logic                   halted,
    output logic                   fetch_start,
    output logic [`CPU_ADDR_W-1:0] fetch_addr,
    input  logic                   fetch_done,
    input  logic [`CPU_XLEN-1:0]   fetch_data,
    output logic                   data_start,
    output logic                   data_write,
    output logic [`CPU_ADDR_W-1:0] data_addr,
    output logic [`CPU_XLEN-1:0]   data_wdata,
    input  logic                   data_done,
    input  logic [`CPU_XLEN-1:0]   data_rdata
);

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_execute_wait,
        st_write,
        st_halt
    } state_t;

    state_t                     state;
    logic [`CPU_ADDR_W-1:0]     pc;
    logic [`CPU_ADDR_W-1:0]     pc_plus4;
    logic [`CPU_ADDR_W-1:0]     pc_target;
    logic [`CPU_ADDR_W-1:0]     next_pc_q;
    logic [`CPU_XLEN-1:0]       inst_q;
    decoded_t                   dec;
    decoded_t                   dec_q;
    logic [`CPU_XLEN-1:0]       result_q;
    logic                       write_q;
    logic [`CPU_REG_ADDR_W-1:0] rs1_addr;
    logic [`CPU_REG_ADDR_W-1:0] rs2_addr;
    logic [`CPU_XLEN-1:0]       rs1_data;
    logic [`CPU_XLEN-1:0]       rs2_data;
    logic                       reg_we;
    logic [`CPU_XLEN-1:0]       alu_b;
    logic [`CPU_XLEN-1:0]       alu_result;
    logic                       alu_equal;
    logic                       taken;

    // write happens at the end of the write state
    assign reg_we = (state == st_write) && write_q;

    regs regs_i (
        .clk    (clk),
        .rstn   (rstn),
        .we     (reg_we),
        .waddr  (dec_q.rd),
        .wdata  (result_q),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    decode decode_i (
        .inst     (inst_q),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec)
    );

    // immediate operand also gives the load and store address
    assign alu_b = (dec_q.cls == cls_alu_reg || dec_q.cls == cls_branch) ? dec_q.rs2 : dec_q.imm;

    alu alu_i (
        .op     (dec_q.op),
        .a      (dec_q.rs1),
        .b      (alu_b),
        .result (alu_result),
        .equal  (alu_equal)
    );

    assign pc_plus4  = pc + `CPU_ADDR_W'(4);
    assign pc_target = pc + dec_q.imm[`CPU_ADDR_W-1:0];
    assign taken     = dec_q.bne ? !alu_equal : alu_equal;

    assign fetch_addr = pc;
    assign halted     = (state == st_halt);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= st_fetch;
            pc          <= `CPU_RESET_PC;
            fetch_start <= 1'b0;
            data_start  <= 1'b0;
            data_write  <= 1'b0;
            write_q     <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    fetch_start <= 1'b1;
                    write_q     <= 1'b0;
                    state       <= st_fetch_wait;
                end
                st_fetch_wait: begin
                    fetch_start <= 1'b0;
                    if (fetch_done) state <= st_decode;
                end
                st_decode: state <= st_execute;
                st_execute: begin
                    case (dec_q.cls)
                        cls_alu_reg, cls_alu_imm, cls_lui, cls_jal: begin
                            write_q <= 1'b1;
                            state   <= st_write;
                        end
                        cls_load, cls_store: begin
                            data_start <= 1'b1;
                            data_write <= (dec_q.cls == cls_store);
                            write_q    <= (dec_q.cls == cls_load);
                            state      <= st_execute_wait;
                        end
                        cls_branch: state <= st_write;
                        // illegal patterns stop the core like ecall
                        default: state <= st_halt;
                    endcase
                end
                st_execute_wait: begin
                    data_start <= 1'b0;
                    if (data_done) state <= st_write;
                end
                st_write: begin
                    pc    <= {next_pc_q[`CPU_ADDR_W-1:2], 2'b00};
                    state <= st_fetch;
                end
                default: state <= st_halt;
            endcase
        end
    end

    // holding registers between the states
    always_ff @(posedge clk) begin
        if (state == st_fetch_wait && fetch_done) inst_q <= fetch_data;
        if (state == st_decode) dec_q <= dec;
        if (state == st_execute) begin
            next_pc_q  <= pc_plus4;
            data_addr  <= {alu_result[`CPU_ADDR_W-1:2], 2'b00};
            data_wdata <= dec_q.rs2;
            case (dec_q.cls)
                cls_lui: result_q <= dec_q.imm;
                cls_jal: begin
                    result_q  <= {{(`CPU_XLEN-`CPU_ADDR_W){1'b0}}, pc_plus4};
                    next_pc_q <= pc_target;
                end
                cls_branch: if (taken) next_pc_q <= pc_target;
                default: result_q <= alu_result;
            endcase
        end
        if (state == st_execute_wait && data_done) result_q <= data_rdata;
    end

endmodule

// File: src/cpu_top.sv
`include "cpu_params.svh"

module cpu_top import bus_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    output logic     halted,
    output apb_req_t bus_req,
    input  apb_rsp_t bus_rsp
);

    logic                   fetch_start;
    logic [`CPU_ADDR_W-1:0] fetch_addr;
    logic                   fetch_done;
    logic [`CPU_XLEN-1:0]   fetch_data;
    logic                   data_start;
    logic                   data_write;
    logic [`CPU_ADDR_W-1:0] data_addr;
    logic [`CPU_XLEN-1:0]   data_wdata;
    logic                   data_done;
    logic [`CPU_XLEN-1:0]   data_rdata;
    apb_req_t               fetch_req;
    apb_req_t               data_req;
    apb_rsp_t               fetch_rsp;
    apb_rsp_t               data_rsp;

    cpu cpu_i (
        .clk         (clk),
        .rstn        (rstn),
        .halted      (halted),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_done),
        .fetch_data  (fetch_data),
        .data_start  (data_start),
        .data_write  (data_write),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_done   (data_done),
        .data_rdata  (data_rdata)
    );

    // instruction port only reads
    bus_master fetch_port (
        .clk   (clk),
        .rstn  (rstn),
        .start (fetch_start),
        .write (1'b0),
        .addr  (fetch_addr),
        .wdata ('0),
        .done  (fetch_done),
        .rdata (fetch_data),
        .req   (fetch_req),
        .rsp   (fetch_rsp)
    );

    bus_master data_port (
        .clk   (clk),
        .rstn  (rstn),
        .start (data_start),
        .write (data_write),
        .addr  (data_addr),
        .wdata (data_wdata),
        .done  (data_done),
        .rdata (data_rdata),
        .req   (data_req),
        .rsp   (data_rsp)
    );

    bus_arbiter bus_arbiter_i (
        .clk       (clk),
        .rstn      (rstn),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp)
    );

endmodule

// File: verification/apb_memory_model.sv
`include "cpu_params.svh"

module apb_memory_model import bus_pkg::*; (
    input  logic     clk,
    input  apb_req_t req,
    output apb_rsp_t rsp
);

    timeunit 1ns;
    timeprecision 100ps;

    // 16 KB of words
    localparam int words = 4096;

    logic [`CPU_XLEN-1:0] mem [0:words-1];
    logic [1:0]           wait_cnt;
    integer               seed;

    initial begin
        seed     = 32'h880e;
        wait_cnt = 2'd0;
        rsp      = '0;
    end

    // response changes on the falling edge, the DUT samples on the rising one
    always @(negedge clk) begin
        if (req.psel && !req.penable) begin
            // 0 to 3 wait states per transfer
            wait_cnt   = 2'($random(seed));
            rsp.pready = 1'b0;
        end else if (req.psel && req.penable && !rsp.pready) begin
            if (wait_cnt == 2'd0) begin
                rsp.pready = 1'b1;
                rsp.prdata = mem[req.paddr[13:2]];
                // transfer is certain to end at the next rising edge
                if (req.pwrite) begin
                    mem[req.paddr[13:2]] = req.pwdata;
                end
            end else begin
                wait_cnt = wait_cnt - 2'd1;
            end
        end else begin
            rsp.pready = 1'b0;
        end
    end

    // each word holds its own byte address in the low half
    task automatic fill_memory();
        for (int i = 0; i < words; i++) begin
            mem[i[11:0]] = {16'hdead, 16'(i * 4)};
        end
    endtask

    task automatic preload(input logic [15:0] addr, input logic [`CPU_XLEN-1:0] data);
        mem[addr[13:2]] = data;
    endtask

    function automatic logic [`CPU_XLEN-1:0] peek(input logic [15:0] addr);
        return mem[addr[13:2]];
    endfunction

endmodule

// File: verification/cpu_top_tb.sv
`include "cpu_params.svh"

module cpu_top_tb
    import bus_pkg::*, isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period      = 20;
    // instructions over all test programs
    localparam int total_insts     = 74;
    localparam int cycles_per_inst = 12;
    // resets, first fetch and the idle check after halt
    localparam int overhead_cycles = 500;
    localparam int watchdog_cycles = total_insts * cycles_per_inst + overhead_cycles;
    localparam logic [15:0] base   = 16'h1000;

    logic        clk;
    logic        rstn;
    logic        halted;
    apb_req_t    bus_req;
    apb_rsp_t    bus_rsp;
    logic [31:0] prog [$];

    cpu_top cpu_top_i (
        .clk     (clk),
        .rstn    (rstn),
        .halted  (halted),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    apb_memory_model mem_i (
        .clk (clk),
        .req (bus_req),
        .rsp (bus_rsp)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // RV32I instruction formats
    function automatic logic [31:0] r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
    endfunction

    function automatic logic [31:0] i_type(logic [6:0] opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] b_type(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] u_type(int rd, int imm20);
        return {imm20[19:0], rd[4:0], opc_lui};
    endfunction

    function automatic logic [31:0] j_type(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
    endfunction

    // value of a word that no store has reached
    function automatic logic [31:0] untouched(input logic [15:0] addr);
        return {16'hdead, addr};
    endfunction

    task automatic push_word(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // register op into x5, then x5 stored at offset from x10
    task automatic alu_store(int f7, int f3, int rs1, int rs2, int offset);
        push_word(r_type(f7, f3, 5, rs1, rs2));
        push_word(s_type(5, 10, offset));
    endtask

    task automatic load_program();
        @(negedge clk);
        rstn = 1'b0;
        mem_i.fill_memory();
        foreach (prog[i]) begin
            mem_i.preload(16'(i * 4), prog[i]);
        end
        prog.delete();
    endtask

    task automatic release_reset();
        repeat (8) begin
            @(negedge clk);
            check_value("psel in reset", 32'(bus_req.psel), 32'h0);
            check_value("penable in reset", 32'(bus_req.penable), 32'h0);
            check_value("halted in reset", 32'(halted), 32'h0);
        end
        rstn = 1'b1;
    endtask

    // every fetch and data address on the bus is word aligned
    task automatic wait_halted();
        int cycles;
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            if (bus_req.psel) begin
                check_value("paddr low bits", 32'(bus_req.paddr[1:0]), 32'h0);
            end
            cycles++;
            if (cycles > 2000) begin
                report_failure("the core did not halt within 2000 cycles");
            end
        end
    endtask

    task automatic test_reset();
        int cycles;
        push_word(`CPU_HALT_INST);
        load_program();
        release_reset();
        cycles = 0;
        while (!bus_req.psel) begin
            check_value("penable", 32'(bus_req.penable), 32'h0);
            check_value("halted", 32'(halted), 32'h0);
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                report_failure("no instruction fetch started after reset");
            end
        end
        check_value("first paddr", 32'(bus_req.paddr), 32'(`CPU_RESET_PC));
        check_value("first pwrite", 32'(bus_req.pwrite), 32'h0);
        check_value("first penable", 32'(bus_req.penable), 32'h0);
        wait_halted();
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] s;
        a = (32'h87654 << 12) + 32'h321;
        b = 32'h0000_070f;
        // -13
        c = 32'hffff_fff3;
        s = 32'h0000_0025;
        push_word(u_type(10, 1));
        push_word(u_type(1, 'h87654));
        push_word(i_type(opc_imm, 0, 1, 1, 'h321));
        push_word(i_type(opc_imm, 0, 2, 0, 'h70f));
        push_word(i_type(opc_imm, 0, 3, 0, -13));
        push_word(i_type(opc_imm, 0, 4, 0, 'h25));
        alu_store(0, 0, 1, 2, 0);
        alu_store('h20, 0, 2, 1, 4);
        alu_store(0, 7, 1, 3, 8);
        alu_store(0, 6, 1, 2, 12);
        alu_store(0, 4, 1, 3, 16);
        alu_store(0, 2, 1, 2, 20);
        alu_store(0, 2, 2, 3, 24);
        alu_store(0, 1, 1, 4, 28);
        alu_store(0, 5, 1, 4, 32);
        push_word(i_type(opc_imm, 0, 5, 1, -2048));
        push_word(s_type(5, 10, 36));
        push_word(u_type(5, 'habcde));
        push_word(s_type(5, 10, 40));
        push_word(s_type(1, 10, 44));
        push_word(`CPU_HALT_INST);
        load_program();
        release_reset();
        wait_halted();
        check_value("add", mem_i.peek(base), a + b);
        check_value("sub", mem_i.peek(base + 16'd4), b - a);
        check_value("and", mem_i.peek(base + 16'd8), a & c);
        check_value("or", mem_i.peek(base + 16'd12), a | b);
        check_value("xor", mem_i.peek(base + 16'd16), a ^ c);
        // a is negative, b positive and c negative
        check_value("slt neg", mem_i.peek(base + 16'd20), 32'h1);
        check_value("slt pos", mem_i.peek(base + 16'd24), 32'h0);
        check_value("sll", mem_i.peek(base + 16'd28), a << s[4:0]);
        check_value("srl", mem_i.peek(base + 16'd32), a >> s[4:0]);
        check_value("addi", mem_i.peek(base + 16'd36), a + 32'hffff_f800);
        check_value("lui", mem_i.peek(base + 16'd40), 32'habcde << 12);
        check_value("lui addi", mem_i.peek(base + 16'd44), a);
    endtask

    task automatic test_memory();
        logic [31:0] stored;
        stored = 32'hc0ff_ee11;
        push_word(u_type(10, 1));
        push_word(i_type(opc_imm, 0, 1, 0, 'h5a5));
        push_word(s_type(1, 10, 0));
        push_word(i_type(opc_load, 2, 2, 10, 0));
        push_word(s_type(2, 10, 4));
        push_word(i_type(opc_load, 2, 3, 10, 'h100));
        push_word(i_type(opc_imm, 0, 3, 3, 1));
        push_word(s_type(3, 10, 8));
        push_word(i_type(opc_imm, 0, 4, 0, -1));
        push_word(s_type(4, 10, 12));
        push_word(i_type(opc_load, 2, 5, 10, 12));
        push_word(s_type(5, 10, 16));
        // unaligned offset falls back to the word at 0x1100
        push_word(i_type(opc_load, 2, 6, 10, 'h103));
        push_word(s_type(6, 10, 20));
        push_word(`CPU_HALT_INST);
        load_program();
        mem_i.preload(base + 16'h100, stored);
        release_reset();
        wait_halted();
        check_value("sw word", mem_i.peek(base), 32'h0000_05a5);
        check_value("lw sw copy", mem_i.peek(base + 16'd4), 32'h0000_05a5);
        check_value("lw addi", mem_i.peek(base + 16'd8), stored + 32'd1);
        check_value("sw before lw", mem_i.peek(base + 16'd12), 32'hffff_ffff);
        check_value("lw after sw", mem_i.peek(base + 16'd16), 32'hffff_ffff);
        check_value("lw aligned", mem_i.peek(base + 16'd20), stored);
        check_value("preloaded word", mem_i.peek(base + 16'h100), stored);
    endtask

    task automatic test_control();
        int jal_pc;
        push_word(u_type(10, 1));
        push_word(i_type(opc_imm, 0, 1, 0, 7));
        push_word(i_type(opc_imm, 0, 2, 0, 7));
        push_word(i_type(opc_imm, 0, 3, 0, 9));
        push_word(i_type(opc_imm, 0, 9, 0, 1));
        // beq taken, beq not taken, bne taken, bne not taken
        push_word(b_type(0, 1, 2, 8));
        push_word(s_type(9, 10, 0));
        push_word(s_type(9, 10, 4));
        push_word(b_type(0, 1, 3, 8));
        push_word(s_type(9, 10, 8));
        push_word(b_type(1, 1, 3, 8));
        push_word(s_type(9, 10, 12));
        push_word(b_type(1, 1, 2, 8));
        push_word(s_type(9, 10, 16));
        jal_pc = prog.size() * 4;
        push_word(j_type(7, 12));
        push_word(s_type(9, 10, 20));
        push_word(s_type(9, 10, 24));
        push_word(s_type(7, 10, 28));
        push_word(`CPU_HALT_INST);
        load_program();
        release_reset();
        wait_halted();
        check_value("beq taken skip", mem_i.peek(base), untouched(base));
        check_value("beq taken target", mem_i.peek(base + 16'd4), 32'h1);
        check_value("beq not taken", mem_i.peek(base + 16'd8), 32'h1);
        check_value("bne taken skip", mem_i.peek(base + 16'd12), untouched(base + 16'd12));
        check_value("bne not taken", mem_i.peek(base + 16'd16), 32'h1);
        check_value("jal skip first", mem_i.peek(base + 16'd20), untouched(base + 16'd20));
        check_value("jal skip second", mem_i.peek(base + 16'd24), untouched(base + 16'd24));
        check_value("jal link", mem_i.peek(base + 16'd28), 32'(jal_pc + 4));
    endtask

    task automatic test_x0_halt();
        push_word(u_type(10, 1));
        push_word(i_type(opc_imm, 0, 0, 0, 'h123));
        push_word(r_type(0, 0, 0, 10, 10));
        push_word(u_type(0, 'h55555));
        push_word(s_type(0, 10, 0));
        push_word(i_type(opc_imm, 0, 1, 0, 0));
        push_word(s_type(1, 10, 4));
        push_word(`CPU_HALT_INST);
        // never reached once the core halts
        push_word(s_type(10, 10, 8));
        load_program();
        release_reset();
        wait_halted();
        repeat (50) begin
            @(negedge clk);
            check_value("halted after ecall", 32'(halted), 32'h1);
            check_value("psel after ecall", 32'(bus_req.psel), 32'h0);
        end
        check_value("x0 stored", mem_i.peek(base), 32'h0);
        check_value("x0 copy", mem_i.peek(base + 16'd4), 32'h0);
        check_value("store after ecall", mem_i.peek(base + 16'd8), untouched(base + 16'd8));
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        report_failure("timeout: the tests did not finish within the watchdog limit");
    end

    initial begin
        clk  = 1'b0;
        rstn = 1'b0;
        test_reset();
        test_alu();
        test_memory();
        test_control();
        test_x0_halt();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: cpu_top.f
+incdir+include
src/isa_pkg.sv
src/bus_pkg.sv
src/regs.sv
src/decode.sv
src/alu.sv
src/bus_master.sv
src/bus_arbiter.sv
src/cpu.sv
src/cpu_top.sv
verification/apb_memory_model.sv
verification/cpu_top_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module cpu_top_tb \
		-f cpu_top.f -o cpu_top_sim
	./obj_dir/cpu_top_sim | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
